/* logic/fused_pkg.sv */
package fused_pkg;

    localparam int addr_w     = 32;   // Byte address width
    localparam int global_w   = 128;  // Global memory word
    localparam int lane_w     = 8;    // One int8 lane
    localparam int word_w     = 32;   // Local buffer read word, four lanes
    localparam int num_pe     = 16;   // PEs, filters and output bytes per word
    localparam int byte_shift = 4;    // Byte address to global word index
    localparam int acc_w      = 32;   // Signed accumulator width
    localparam int relu6_max  = 6;    // ReLU6 upper clamp

    typedef logic [addr_w-1:0]   addr_t;
    typedef logic [global_w-1:0] gword_t;
    typedef logic [word_w-1:0]   lword_t;
    typedef logic [15:0]         dim_t;   // Widths and channel counts

endpackage

/* logic/bram_general.sv */
`timescale 1ns/1ps

module bram_general #(
    parameter int depth      = 1024,
    parameter int in_w       = 128,
    parameter int out_w      = 32,
    parameter int byte_shift = 4
) (
    input  logic             clk,
    input  logic             we,
    input  fused_pkg::addr_t wr_addr,
    input  fused_pkg::addr_t rd_addr,
    input  logic [in_w-1:0]  data_in,
    output logic [out_w-1:0] data_out
);
    localparam int ratio    = in_w / out_w;       // Read slices per stored word
    localparam int rd_shift = $clog2(out_w / 8);  // Byte address to slice index

    logic [in_w-1:0]  mem [depth];
    fused_pkg::addr_t wr_idx;
    fused_pkg::addr_t rd_idx;
    fused_pkg::addr_t rd_sel;

    assign wr_idx = wr_addr >> byte_shift;
    assign rd_idx = rd_addr >> byte_shift;
    assign rd_sel = (rd_addr >> rd_shift) % ratio;  // Slice within the wide word

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_idx] <= data_in;
        end
        data_out <= mem[rd_idx][rd_sel*out_w +: out_w];  // One cycle read latency
    end

    wr_in_range: assert property (@(posedge clk) we |-> wr_idx < depth)
        else $error("bram_general write index %0d beyond depth %0d", wr_idx, depth);

endmodule

/* logic/global_control_unit.sv */
`timescale 1ns/1ps

module global_control_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  fused_pkg::addr_t             base_addr_ifm,
    input  fused_pkg::addr_t             size_ifm,
    input  fused_pkg::addr_t             base_addr_weight,
    input  fused_pkg::addr_t             size_weight,
    input  logic                         done_compute,
    output fused_pkg::addr_t             rd_addr_global,
    output fused_pkg::addr_t             local_wr_addr,
    output logic                         ifm_we,
    output logic [fused_pkg::num_pe-1:0] weight_we,
    output logic                         compute_start,
    output logic                         busy
);
    localparam int filt_shift = fused_pkg::byte_shift + $clog2(fused_pkg::num_pe);

    typedef enum logic [1:0] {
        st_idle,
        st_copy_ifm,
        st_copy_wt
    } state_t;

    state_t                               state;
    fused_pkg::addr_t                     cnt;        // Words read in current region
    fused_pkg::addr_t                     buf_off;    // Word offset in the weight buffer
    logic [$clog2(fused_pkg::num_pe)-1:0] buf_idx;    // Destination weight buffer
    fused_pkg::addr_t                     ifm_last;
    fused_pkg::addr_t                     wt_last;
    fused_pkg::addr_t                     filt_last;
    logic                                 last_wr;

    assign ifm_last  = (size_ifm >> fused_pkg::byte_shift) - 1;
    assign wt_last   = (size_weight >> fused_pkg::byte_shift) - 1;
    assign filt_last = (size_weight >> filt_shift) - 1;  // Words per filter minus one

    assign rd_addr_global = (state == st_copy_wt ? base_addr_weight : base_addr_ifm)
                          + (cnt << fused_pkg::byte_shift);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            cnt     <= '0;
            buf_off <= '0;
            buf_idx <= '0;
            busy    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start && !busy) begin  // Start during a run is dropped
                        state <= st_copy_ifm;
                        cnt   <= '0;
                        busy  <= 1'b1;
                    end
                end
                st_copy_ifm: begin
                    if (cnt == ifm_last) begin
                        state   <= st_copy_wt;
                        cnt     <= '0;
                        buf_off <= '0;
                        buf_idx <= '0;
                    end else begin
                        cnt <= cnt + 1;
                    end
                end
                st_copy_wt: begin
                    cnt <= cnt + 1;
                    if (buf_off == filt_last) begin  // Next filter block
                        buf_off <= '0;
                        buf_idx <= buf_idx + 1;
                    end else begin
                        buf_off <= buf_off + 1;
                    end
                    if (cnt == wt_last) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
            if (done_compute) begin
                busy <= 1'b0;
            end
        end
    end

    // Write stage lines up with the global read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ifm_we        <= 1'b0;
            weight_we     <= '0;
            last_wr       <= 1'b0;
            compute_start <= 1'b0;
        end else begin
            ifm_we    <= (state == st_copy_ifm);
            weight_we <= '0;
            if (state == st_copy_wt) begin
                weight_we[buf_idx] <= 1'b1;
            end
            last_wr       <= (state == st_copy_wt) && (cnt == wt_last);
            compute_start <= last_wr;  // Pulse once the last word is stored
        end
    end

    always_ff @(posedge clk) begin
        local_wr_addr <= (state == st_copy_wt ? buf_off : cnt) << fused_pkg::byte_shift;
    end

endmodule

/* logic/address_generator.sv */
`timescale 1ns/1ps

module address_generator (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             compute_start,
    input  logic [3:0]       kernel_w,
    input  logic [1:0]       stride,
    input  fused_pkg::dim_t  ifm_w,
    input  fused_pkg::dim_t  ifm_c,
    input  fused_pkg::dim_t  ofm_w,
    output fused_pkg::addr_t addr_ifm,
    output fused_pkg::addr_t addr_filter,
    output logic             addr_valid,
    output logic             mac_en,
    output logic             window_first,
    output logic             window_last,
    output logic             done_compute
);
    localparam int lane_shift = $clog2(fused_pkg::word_w / fused_pkg::lane_w);

    fused_pkg::dim_t  cg;        // Channel group
    fused_pkg::dim_t  kx;
    fused_pkg::dim_t  ky;
    fused_pkg::dim_t  ox;        // Output pixel
    fused_pkg::dim_t  oy;
    fused_pkg::dim_t  cg_num;
    fused_pkg::dim_t  k_last;
    fused_pkg::dim_t  o_last;
    logic             active;
    logic             cg_wrap;
    logic             kx_wrap;
    logic             ky_wrap;
    logic             ox_wrap;
    logic             oy_wrap;
    fused_pkg::addr_t iy;
    fused_pkg::addr_t ix;

    assign cg_num = ifm_c >> lane_shift;
    assign k_last = fused_pkg::dim_t'(kernel_w) - 1;
    assign o_last = ofm_w - 1;  // Square OFM

    assign cg_wrap = (cg == cg_num - 1);
    assign kx_wrap = cg_wrap && (kx == k_last);
    assign ky_wrap = kx_wrap && (ky == k_last);  // Window ends
    assign ox_wrap = ky_wrap && (ox == o_last);
    assign oy_wrap = ox_wrap && (oy == o_last);  // Last window of the run

    // Window origin is the output position times the stride
    assign iy = fused_pkg::addr_t'(oy) * fused_pkg::addr_t'(stride) + fused_pkg::addr_t'(ky);
    assign ix = fused_pkg::addr_t'(ox) * fused_pkg::addr_t'(stride) + fused_pkg::addr_t'(kx);

    assign addr_ifm = ((iy * fused_pkg::addr_t'(ifm_w) + ix) * fused_pkg::addr_t'(cg_num)
                    + fused_pkg::addr_t'(cg)) << lane_shift;
    assign addr_filter = ((fused_pkg::addr_t'(ky) * fused_pkg::addr_t'(kernel_w)
                       + fused_pkg::addr_t'(kx)) * fused_pkg::addr_t'(cg_num)
                       + fused_pkg::addr_t'(cg)) << lane_shift;
    assign addr_valid = active;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            cg     <= '0;
            kx     <= '0;
            ky     <= '0;
            ox     <= '0;
            oy     <= '0;
        end else if (compute_start && !active) begin
            active <= 1'b1;
            cg     <= '0;
            kx     <= '0;
            ky     <= '0;
            ox     <= '0;
            oy     <= '0;
        end else if (active) begin
            cg <= cg_wrap ? '0 : cg + 1;
            if (cg_wrap) begin
                kx <= kx_wrap ? '0 : kx + 1;
            end
            if (kx_wrap) begin
                ky <= ky_wrap ? '0 : ky + 1;
            end
            if (ky_wrap) begin
                ox <= ox_wrap ? '0 : ox + 1;
            end
            if (ox_wrap) begin
                oy <= oy_wrap ? '0 : oy + 1;
            end
            if (oy_wrap) begin
                active <= 1'b0;
            end
        end
    end

    // Strobes trail the addresses by the buffer read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mac_en       <= 1'b0;
            window_first <= 1'b0;
            window_last  <= 1'b0;
            done_compute <= 1'b0;
        end else begin
            mac_en       <= active;
            window_first <= active && (cg == 0) && (kx == 0) && (ky == 0);
            window_last  <= active && ky_wrap;
            done_compute <= active && oy_wrap;
        end
    end

    window_in_ifm: assert property (@(posedge clk) disable iff (!rst_n)
        addr_valid |-> (ix < fused_pkg::addr_t'(ifm_w)) && (iy < fused_pkg::addr_t'(ifm_w)))
        else $error("IFM window at x %0d y %0d beyond width %0d", ix, iy, ifm_w);

endmodule

/* logic/pe_cluster.sv */
`timescale 1ns/1ps

module pe_cluster (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     mac_en,
    input  logic                                     window_first,
    input  logic                                     window_last,
    input  fused_pkg::lword_t                        ifm_word,
    input  fused_pkg::lword_t [fused_pkg::num_pe-1:0] weights,
    output fused_pkg::gword_t                        ofm_word,
    output logic                                     out_valid
);
    localparam int lanes = fused_pkg::word_w / fused_pkg::lane_w;
    localparam int lw    = fused_pkg::lane_w;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= mac_en && window_last;  // Packed word ready next cycle
        end
    end

    for (genvar f = 0; f < fused_pkg::num_pe; f++) begin : g_pe
        logic signed [fused_pkg::acc_w-1:0] acc;
        logic signed [fused_pkg::acc_w-1:0] psum;      // Four lane products
        logic signed [fused_pkg::acc_w-1:0] acc_next;
        logic [lw-1:0]                      relu_q;

        always_comb begin
            psum = '0;
            for (int l = 0; l < lanes; l++) begin
                psum = psum + signed'(ifm_word[l*lw +: lw]) * signed'(weights[f][l*lw +: lw]);
            end
        end

        assign acc_next = window_first ? psum : acc + psum;  // First word restarts

        always_ff @(posedge clk) begin
            if (mac_en) begin
                acc <= acc_next;
            end
            if (mac_en && window_last) begin  // ReLU6 on the full window sum
                if (acc_next < 0) begin
                    relu_q <= '0;
                end else if (acc_next > fused_pkg::relu6_max) begin
                    relu_q <= lw'(fused_pkg::relu6_max);
                end else begin
                    relu_q <= acc_next[lw-1:0];
                end
            end
        end

        assign ofm_word[f*lw +: lw] = relu_q;  // Filter f in byte f
    end

endmodule

/* logic/ofm_writer.sv */
`timescale 1ns/1ps

module ofm_writer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              out_valid,
    input  fused_pkg::gword_t ofm_word,
    input  fused_pkg::addr_t  ofm_base_addr,
    input  logic              done_compute,
    output logic              we_global,
    output fused_pkg::addr_t  wr_addr_global,
    output fused_pkg::gword_t data_global,
    output logic              done
);
    fused_pkg::addr_t pix;      // Output pixel, row-major
    logic             pending;  // Last window in flight

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_global <= 1'b0;
            done      <= 1'b0;
            pix       <= '0;
            pending   <= 1'b0;
        end else begin
            we_global <= out_valid;
            done      <= we_global && pending;  // One cycle after the final write
            if (out_valid) begin
                pix <= pending ? '0 : pix + 1;  // Rewinds so the next run starts at base
            end
            if (done_compute) begin
                pending <= 1'b1;
            end else if (we_global && pending) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_valid) begin
            data_global    <= ofm_word;
            wr_addr_global <= ofm_base_addr + (pix << fused_pkg::byte_shift);
        end
    end

endmodule

/* logic/fused_conv_top.sv */
`timescale 1ns/1ps

module fused_conv_top #(
    parameter int global_depth = 4096,
    parameter int ifm_depth    = 1024,
    parameter int weight_depth = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_phase,
    input  logic              we_load,
    input  fused_pkg::addr_t  wr_addr_load,
    input  fused_pkg::addr_t  rd_addr_load,
    input  fused_pkg::gword_t data_load,
    input  logic              start,
    input  fused_pkg::addr_t  base_addr_ifm,
    input  fused_pkg::addr_t  size_ifm,
    input  fused_pkg::addr_t  base_addr_weight,
    input  fused_pkg::addr_t  size_weight,
    input  fused_pkg::addr_t  ofm_base_addr,
    input  logic [3:0]        kernel_w,
    input  logic [1:0]        stride,
    input  fused_pkg::dim_t   ifm_w,
    input  fused_pkg::dim_t   ifm_c,
    input  fused_pkg::dim_t   ofm_w,
    output fused_pkg::gword_t data_out,
    output logic              busy,
    output logic              done
);
    fused_pkg::addr_t                         rd_addr_ctl;
    fused_pkg::addr_t                         local_wr_addr;
    fused_pkg::addr_t                         addr_ifm;
    fused_pkg::addr_t                         addr_filter;
    fused_pkg::addr_t                         wr_addr_ofm;
    fused_pkg::addr_t                         g_wr_addr;
    fused_pkg::addr_t                         g_rd_addr;
    fused_pkg::gword_t                        g_data_in;
    fused_pkg::gword_t                        ofm_word;
    fused_pkg::gword_t                        data_ofm;
    fused_pkg::lword_t                        ifm_word;
    fused_pkg::lword_t [fused_pkg::num_pe-1:0] weights;
    logic [fused_pkg::num_pe-1:0]             weight_we;
    logic                                     g_we;
    logic                                     we_ofm;
    logic                                     ifm_we;
    logic                                     compute_start;
    logic                                     mac_en;
    logic                                     window_first;
    logic                                     window_last;
    logic                                     done_compute;
    logic                                     out_valid;

    // Host owns the global port while loading
    assign g_we      = load_phase ? we_load      : we_ofm;
    assign g_wr_addr = load_phase ? wr_addr_load : wr_addr_ofm;
    assign g_data_in = load_phase ? data_load    : data_ofm;
    assign g_rd_addr = load_phase ? rd_addr_load : rd_addr_ctl;

    bram_general #(
        .depth(global_depth), .in_w(128), .out_w(128), .byte_shift(fused_pkg::byte_shift)
    ) global_mem_i (
        .clk(clk), .we(g_we), .wr_addr(g_wr_addr), .rd_addr(g_rd_addr),
        .data_in(g_data_in), .data_out(data_out)
    );

    bram_general #(
        .depth(ifm_depth), .in_w(128), .out_w(32), .byte_shift(fused_pkg::byte_shift)
    ) ifm_buf_i (
        .clk(clk), .we(ifm_we), .wr_addr(local_wr_addr), .rd_addr(addr_ifm),
        .data_in(data_out), .data_out(ifm_word)
    );

    for (genvar f = 0; f < fused_pkg::num_pe; f++) begin : g_wbuf
        bram_general #(
            .depth(weight_depth), .in_w(128), .out_w(32), .byte_shift(fused_pkg::byte_shift)
        ) wbuf_i (
            .clk(clk), .we(weight_we[f]), .wr_addr(local_wr_addr), .rd_addr(addr_filter),
            .data_in(data_out), .data_out(weights[f])
        );
    end

    global_control_unit ctrl_i (
        .clk(clk), .rst_n(rst_n), .start(start),
        .base_addr_ifm(base_addr_ifm), .size_ifm(size_ifm),
        .base_addr_weight(base_addr_weight), .size_weight(size_weight),
        .done_compute(done),  // Busy covers the write-back too
        .rd_addr_global(rd_addr_ctl), .local_wr_addr(local_wr_addr),
        .ifm_we(ifm_we), .weight_we(weight_we),
        .compute_start(compute_start), .busy(busy)
    );

    address_generator addr_gen_i (
        .clk(clk), .rst_n(rst_n), .compute_start(compute_start),
        .kernel_w(kernel_w), .stride(stride), .ifm_w(ifm_w), .ifm_c(ifm_c), .ofm_w(ofm_w),
        .addr_ifm(addr_ifm), .addr_filter(addr_filter), .addr_valid(),
        .mac_en(mac_en), .window_first(window_first), .window_last(window_last),
        .done_compute(done_compute)
    );

    pe_cluster pe_cluster_i (
        .clk(clk), .rst_n(rst_n), .mac_en(mac_en),
        .window_first(window_first), .window_last(window_last),
        .ifm_word(ifm_word), .weights(weights),
        .ofm_word(ofm_word), .out_valid(out_valid)
    );

    ofm_writer ofm_writer_i (
        .clk(clk), .rst_n(rst_n), .out_valid(out_valid), .ofm_word(ofm_word),
        .ofm_base_addr(ofm_base_addr), .done_compute(done_compute),
        .we_global(we_ofm), .wr_addr_global(wr_addr_ofm), .data_global(data_ofm),
        .done(done)
    );

endmodule

/* tb/conv_ref_model.svh */
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

// Full precision sum of one filter over the window of output pixel (oy, ox)
function automatic int window_sum(input int f, input int oy, input int ox, input int kw,
                                  input int s, input int iw, input int ic);
    int sum;
    int fb;
    int pix;
    sum = 0;
    fb  = kw * kw * ic;  // Bytes per filter
    for (int ky = 0; ky < kw; ky++) begin
        for (int kx = 0; kx < kw; kx++) begin
            pix = (oy * s + ky) * iw + (ox * s + kx);
            for (int ch = 0; ch < ic; ch++) begin
                sum = sum + int'(ifm_mem[pix * ic + ch])
                          * int'(wt_mem[f * fb + (ky * kw + kx) * ic + ch]);
            end
        end
    end
    return sum;
endfunction

// Expected packed word for one output pixel, filter f in byte f
task automatic expected_pixel(input int oy, input int ox, input int kw, input int s,
                              input int iw, input int ic, output fused_pkg::gword_t word);
    int v;
    word = '0;
    for (int f = 0; f < fused_pkg::num_pe; f++) begin
        v = window_sum(f, oy, ox, kw, s, iw, ic);
        if (v < 0) begin
            n_low++;
            word[8*f +: 8] = 8'd0;
        end else if (v > 6) begin
            n_high++;
            word[8*f +: 8] = 8'd6;  // ReLU6 ceiling
        end else begin
            word[8*f +: 8] = 8'(v);
        end
    end
endtask

`endif

/* tb/tb_fused_conv.sv */
`timescale 1ns/1ps

module tb_fused_conv;

    localparam int runs       = 4;
    localparam int ifm_base   = 'h0000;
    localparam int wt_base    = 'h1000;
    localparam int ofm_base   = 'h4000;
    localparam int scratch    = 'h8000;  // Spare word for the load check
    localparam int max_cycles = 20000;

    logic              clk;
    logic              rst_n;
    logic              load_phase;
    logic              we_load;
    logic              start;
    fused_pkg::addr_t  wr_addr_load;
    fused_pkg::addr_t  rd_addr_load;
    fused_pkg::addr_t  base_addr_ifm;
    fused_pkg::addr_t  size_ifm;
    fused_pkg::addr_t  base_addr_weight;
    fused_pkg::addr_t  size_weight;
    fused_pkg::addr_t  ofm_base_addr;
    fused_pkg::gword_t data_load;
    fused_pkg::gword_t data_out;
    logic [3:0]        kernel_w;
    logic [1:0]        stride;
    fused_pkg::dim_t   ifm_w;
    fused_pkg::dim_t   ifm_c;
    fused_pkg::dim_t   ofm_w;
    logic              busy;
    logic              done;

    logic signed [7:0] ifm_mem [0:1023];  // IFM bytes, pixel major
    logic signed [7:0] wt_mem  [0:4095];  // Filter blocks back to back
    fused_pkg::gword_t exp_words [0:63];
    int                n_low;
    int                n_high;
    integer            seed = 32'hfc1a;

    // Run table: kernel_w, stride, ifm_w, ifm_c
    int tab_kw     [runs] = '{1, 3, 3, 2};
    int tab_stride [runs] = '{1, 1, 2, 2};
    int tab_iw     [runs] = '{4, 5, 7, 6};
    int tab_ic     [runs] = '{16, 16, 16, 4};

    `include "conv_ref_model.svh"

    fused_conv_top dut_i (
        .clk(clk), .rst_n(rst_n), .load_phase(load_phase), .we_load(we_load),
        .wr_addr_load(wr_addr_load), .rd_addr_load(rd_addr_load), .data_load(data_load),
        .start(start), .base_addr_ifm(base_addr_ifm), .size_ifm(size_ifm),
        .base_addr_weight(base_addr_weight), .size_weight(size_weight),
        .ofm_base_addr(ofm_base_addr), .kernel_w(kernel_w), .stride(stride),
        .ifm_w(ifm_w), .ifm_c(ifm_c), .ofm_w(ofm_w),
        .data_out(data_out), .busy(busy), .done(done)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            fail_run("a checked value did not match");
        end
    endtask

    function automatic fused_pkg::gword_t fill_word(input fused_pkg::addr_t a);
        return {a, ~a, a ^ 32'h5a5a_c3c3, a + 32'h0137_9bdf};
    endfunction

    function automatic fused_pkg::gword_t pack_word(input bit from_ifm, input int i);
        fused_pkg::gword_t w;
        for (int j = 0; j < 16; j++) begin
            w[8*j +: 8] = from_ifm ? ifm_mem[16*i + j] : wt_mem[16*i + j];  // Byte j at bit 8j
        end
        return w;
    endfunction

    task automatic write_word(input fused_pkg::addr_t a, input fused_pkg::gword_t d);
        @(negedge clk);
        we_load      = 1'b1;
        wr_addr_load = a;
        data_load    = d;
    endtask

    task automatic read_word(input fused_pkg::addr_t a, output fused_pkg::gword_t d);
        @(negedge clk);
        we_load      = 1'b0;
        rd_addr_load = a;
        @(negedge clk);
        d = data_out;  // One cycle read latency
    endtask

    task automatic run_row(input int r);
        int                kw;
        int                s;
        int                iw;
        int                ic;
        int                ow;
        int                npix;
        int                ifm_bytes;
        int                wt_bytes;
        int                copy_len;
        int                comp_len;
        int                cyc;
        int                done_cnt;
        fused_pkg::addr_t  a;
        fused_pkg::gword_t got;
        kw        = tab_kw[r];
        s         = tab_stride[r];
        iw        = tab_iw[r];
        ic        = tab_ic[r];
        ow        = (iw - kw) / s + 1;
        npix      = ow * ow;
        ifm_bytes = iw * iw * ic;
        wt_bytes  = fused_pkg::num_pe * kw * kw * ic;
        copy_len  = ifm_bytes / 16 + wt_bytes / 16 + 1;
        comp_len  = npix * kw * kw * ic / 4;  // One word per cycle over all windows
        for (int i = 0; i < ifm_bytes; i++) begin
            ifm_mem[i] = 8'($random(seed) % 3);  // Lanes in -2..2
        end
        for (int i = 0; i < wt_bytes; i++) begin
            wt_mem[i] = 8'($random(seed) % 3);
        end
        @(negedge clk);
        load_phase = 1'b1;
        for (int i = 0; i < ifm_bytes / 16; i++) begin
            write_word(fused_pkg::addr_t'(ifm_base + 16*i), pack_word(1'b1, i));
        end
        for (int i = 0; i < wt_bytes / 16; i++) begin
            write_word(fused_pkg::addr_t'(wt_base + 16*i), pack_word(1'b0, i));
        end
        for (int p = -1; p <= npix; p++) begin  // OFM region plus a word on each side
            a = fused_pkg::addr_t'(ofm_base + 16*p);
            write_word(a, fill_word(a));
        end
        @(negedge clk);
        we_load     = 1'b0;
        load_phase  = 1'b0;
        kernel_w    = 4'(kw);
        stride      = 2'(s);
        ifm_w       = 16'(iw);
        ifm_c       = 16'(ic);
        ofm_w       = 16'(ow);
        size_ifm    = fused_pkg::addr_t'(ifm_bytes);
        size_weight = fused_pkg::addr_t'(wt_bytes);
        n_low       = 0;
        n_high      = 0;
        for (int p = 0; p < npix; p++) begin
            expected_pixel(p / ow, p % ow, kw, s, iw, ic, exp_words[p]);
        end
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value("busy", busy, 1);
        cyc      = 0;
        done_cnt = 0;
        while (done_cnt == 0) begin
            @(negedge clk);
            cyc++;
            start = (cyc >= 3);  // Start held high while busy
            if (done) begin
                done_cnt++;
            end
            check_value("busy", busy, 1);
            if (cyc > max_cycles) begin
                fail_run("timeout: done never arrived after start");
            end
        end
        start = 1'b0;
        repeat (copy_len + comp_len + 8) begin  // Single pulse, and no rerun follows
            @(negedge clk);
            check_value("done", done, 0);
            check_value("busy", busy, 0);
        end
        load_phase = 1'b1;
        for (int p = 0; p < npix; p++) begin
            read_word(fused_pkg::addr_t'(ofm_base + 16*p), got);
            check_value($sformatf("data_out ofm pixel %0d", p), got, exp_words[p]);
        end
        a = fused_pkg::addr_t'(ofm_base + 16*npix);
        read_word(a, got);
        check_value("data_out guard after ofm", got, fill_word(a));
        a = fused_pkg::addr_t'(ofm_base - 16);
        read_word(a, got);
        check_value("data_out guard before ofm", got, fill_word(a));
        load_phase = 1'b0;
        if (kw == 3) begin
            check_value("clamped to 0 seen", n_low > 0, 1);
            check_value("clamped to 6 seen", n_high > 0, 1);
        end
    endtask

    initial begin
        fused_pkg::gword_t got;
        clk              = 1'b0;
        rst_n            = 1'b0;
        load_phase       = 1'b0;
        we_load          = 1'b0;
        start            = 1'b0;
        wr_addr_load     = '0;
        rd_addr_load     = '0;
        data_load        = '0;
        base_addr_ifm    = fused_pkg::addr_t'(ifm_base);
        size_ifm         = '0;
        base_addr_weight = fused_pkg::addr_t'(wt_base);
        size_weight      = '0;
        ofm_base_addr    = fused_pkg::addr_t'(ofm_base);
        kernel_w         = '0;
        stride           = '0;
        ifm_w            = '0;
        ifm_c            = '0;
        ofm_w            = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        load_phase = 1'b1;
        write_word(fused_pkg::addr_t'(scratch), fill_word(fused_pkg::addr_t'(scratch)));
        read_word(fused_pkg::addr_t'(scratch), got);
        check_value("data_out", got, fill_word(fused_pkg::addr_t'(scratch)));
        load_phase = 1'b0;
        for (int r = 0; r < runs; r++) begin
            run_row(r);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+tb
logic/fused_pkg.sv
logic/bram_general.sv
logic/global_control_unit.sv
logic/address_generator.sv
logic/pe_cluster.sv
logic/ofm_writer.sv
logic/fused_conv_top.sv
tb/tb_fused_conv.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_fused_conv
FILELIST = flist.f
LOG      = sim.log
PASS_MSG = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
